// ==== verilog.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_write_stage.sv
logic/csr_exc_regs.sv
logic/csr_timer.sv
logic/csr_scratch_regs.sv
logic/csr_read_mux.sv
logic/csr_top.sv
verif/csr_chk.sv
verif/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - include_dirs:
      - logic
    files:
      - logic/csr_pkg.sv
      - logic/csr_write_stage.sv
      - logic/csr_exc_regs.sv
      - logic/csr_timer.sv
      - logic/csr_scratch_regs.sv
      - logic/csr_read_mux.sv
      - logic/csr_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/csr_chk.sv
      - verif/csr_tb.sv

// ==== verif/csr_tb.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int WAIT_LIMIT = 200;

    // Every kept CSR, TICLR and one unmapped number
    localparam csr_addr_t RESET_CHECK [15] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TCFG, `CSR_TVAL,
        `CSR_TICLR, 14'h3ff
    };
    localparam csr_addr_t RAND_TARGETS [6] = '{
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_EENTRY, `CSR_ECFG
    };

    logic       clk = 1'b0;
    logic       aresetn;
    logic       wen_in;
    csr_addr_t  addr_in;
    csr_data_t  wdata_in;
    logic       d_idle;
    logic       flush;
    logic       exception;
    logic       ertn;
    logic       wen_expcode;
    logic [6:0] expcode_in;
    logic       wen_era;
    csr_data_t  era_in;
    logic       wen_badv;
    csr_data_t  badv_in;
    logic [7:0] hardware_interrupt;
    csr_data_t  rdata;
    crmd_t      crmd;
    csr_data_t  estat;
    csr_data_t  era_out;
    csr_data_t  eentry;
    logic       cpu_interrupt;
    logic       idle_over;
    logic       write_pending;

    // Shadow model of the register file
    crmd_t       m_crmd;
    prmd_t       m_prmd;
    logic [12:0] m_lie;
    logic [1:0]  m_soft;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    csr_data_t   m_era;
    csr_data_t   m_badv;
    csr_data_t   m_eentry;
    csr_data_t   m_save [4];
    csr_data_t   m_tcfg;
    logic [7:0]  m_hw;
    logic        m_timer;

    integer      seed;
    csr_addr_t   read_q [$];

    csr_top i_dut (
        .clk                (clk),
        .aresetn            (aresetn),
        .wen_in             (wen_in),
        .addr_in            (addr_in),
        .wdata_in           (wdata_in),
        .d_idle             (d_idle),
        .flush              (flush),
        .exception          (exception),
        .ertn               (ertn),
        .wen_expcode        (wen_expcode),
        .expcode_in         (expcode_in),
        .wen_era            (wen_era),
        .era_in             (era_in),
        .wen_badv           (wen_badv),
        .badv_in            (badv_in),
        .hardware_interrupt (hardware_interrupt),
        .rdata              (rdata),
        .crmd               (crmd),
        .estat              (estat),
        .era_out            (era_out),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over),
        .write_pending      (write_pending)
    );

    always #5 clk = ~clk;

    function automatic int_vec_t model_vec();
        return {1'b0, m_timer, 1'b0, m_hw, m_soft};
    endfunction

    function automatic csr_data_t expected_read(input csr_addr_t addr);
        case (addr)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return {19'd0, m_lie};
            `CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'd0, model_vec()};
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TCFG:   return m_tcfg;
            // Counter is only read before its first load
            `CSR_TVAL:   return 32'd0;
            default:     return 32'd0;
        endcase
    endfunction

    function automatic void apply_write(input csr_addr_t addr, input csr_data_t data);
        crmd_t c;
        prmd_t p;
        c = crmd_t'(data);
        p = prmd_t'(data);
        case (addr)
            `CSR_CRMD: begin
                m_crmd.plv  = c.plv;
                m_crmd.ie   = c.ie;
                m_crmd.datf = c.datf;
                m_crmd.datm = c.datm;
                if (c.pg != c.da) begin
                    m_crmd.pg = c.pg;
                    m_crmd.da = c.da;
                end
            end
            `CSR_PRMD: begin
                m_prmd.pplv = p.pplv;
                m_prmd.pie  = p.pie;
            end
            `CSR_ECFG:   m_lie = data[12:0] & `CSR_ECFG_LIE_MASK;
            `CSR_ESTAT:  m_soft = data[1:0];
            `CSR_ERA:    m_era = data;
            `CSR_BADV:   m_badv = data;
            `CSR_EENTRY: m_eentry = data & `CSR_EENTRY_MASK;
            `CSR_SAVE0:  m_save[0] = data;
            `CSR_SAVE1:  m_save[1] = data;
            `CSR_SAVE2:  m_save[2] = data;
            `CSR_SAVE3:  m_save[3] = data;
            `CSR_TCFG:   m_tcfg = data;
            `CSR_TICLR:  m_timer = 1'b0;
            default:     ;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s expected 0x%08h got 0x%08h",
                                     $time, name, exp, act));
        end
    endtask

    // Reads one queued address per cycle and compares with the model
    initial begin : compare_reads
        csr_addr_t a;
        forever begin
            @(posedge clk);
            if (read_q.size() != 0) begin
                a = read_q[0];
                addr_in <= a;
                @(negedge clk);
                compare_value($sformatf("rdata(csr 0x%03h)", a), expected_read(a), rdata);
                read_q.delete(0);
            end
        end
    end

    task automatic read_check(input csr_addr_t addr);
        int n;
        n = 0;
        read_q.push_back(addr);
        while (read_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (read_q.size() != 0) begin
            report_failure("Timeout: the compare process never completed a read");
        end
    endtask

    task automatic issue_write(input csr_addr_t addr, input csr_data_t data);
        @(posedge clk);
        wen_in   <= 1'b1;
        addr_in  <= addr;
        wdata_in <= data;
        @(posedge clk);
        wen_in <= 1'b0;
    endtask

    // Counts edges from capture until write_pending falls
    task automatic wait_commit(output int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (write_pending && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (write_pending) begin
            report_failure("Timeout: the staged write never committed");
        end
        cycles = n;
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
        int n;
        issue_write(addr, data);
        wait_commit(n);
        compare_value("commit delay", `CSR_COMMIT_IDLE, n);
        apply_write(addr, data);
    endtask

    task automatic drive_lines(input logic [7:0] lines);
        @(posedge clk);
        hardware_interrupt <= lines;
        m_hw = lines;
    endtask

    task automatic check_irq();
        logic exp_int;
        @(negedge clk);
        exp_int = m_crmd.ie && ((m_lie & model_vec()) != 13'd0);
        compare_value("cpu_interrupt", exp_int, cpu_interrupt);
        compare_value("idle_over", model_vec() != 13'd0, idle_over);
    endtask

    task automatic wait_timer_bit();
        int n;
        n = 0;
        @(negedge clk);
        while (!estat[11] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!estat[11]) begin
            report_failure("Timeout: the timer bit in ESTAT never rose");
        end
        m_timer = 1'b1;
    endtask

    always @(negedge clk) begin
        if (i_dut.i_chk.fail_count != 0) begin
            report_failure("A concurrent assertion in the bound checker failed");
        end
    end

    initial begin : main_seq
        crmd_t     c;
        tcfg_t     t;
        csr_data_t d;
        int        n;
        seed               = 32'hbd53acfb;
        aresetn            = 1'b0;
        wen_in             = 1'b0;
        addr_in            = '0;
        wdata_in           = '0;
        d_idle             = 1'b1;
        flush              = 1'b0;
        exception          = 1'b0;
        ertn               = 1'b0;
        wen_expcode        = 1'b0;
        expcode_in         = '0;
        wen_era            = 1'b0;
        era_in             = '0;
        wen_badv           = 1'b0;
        badv_in            = '0;
        hardware_interrupt = '0;
        m_crmd   = `CSR_CRMD_RESET;
        m_prmd   = '0;
        m_lie    = '0;
        m_soft   = '0;
        m_ecode  = '0;
        m_esub   = '0;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        m_tcfg   = '0;
        m_hw     = '0;
        m_timer  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end

        repeat (10) @(posedge clk);
        aresetn <= 1'b1;

        foreach (RESET_CHECK[i]) begin
            read_check(RESET_CHECK[i]);
        end

        // Random writes with d_idle held high
        for (int i = 0; i < 12; i++) begin
            d = $random(seed);
            write_csr(RAND_TARGETS[i % 6], d);
            read_check(RAND_TARGETS[i % 6]);
            compare_value("eentry", m_eentry, eentry);
        end

        // Back-pressure from d_idle
        d = $random(seed);
        @(posedge clk);
        d_idle <= 1'b0;
        issue_write(`CSR_SAVE2, d);
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            compare_value("write_pending", 1, write_pending);
        end
        read_check(`CSR_SAVE2);
        @(posedge clk);
        d_idle <= 1'b1;
        wait_commit(n);
        compare_value("commit delay after d_idle", `CSR_COMMIT_IDLE, n);
        apply_write(`CSR_SAVE2, d);
        read_check(`CSR_SAVE2);

        // Flush drops the staged write
        d = $random(seed);
        issue_write(`CSR_SAVE1, d);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        compare_value("write_pending", 0, write_pending);
        repeat (`CSR_COMMIT_IDLE + 2) @(posedge clk);
        read_check(`CSR_SAVE1);

        // PG/DA legality
        c      = '0;
        c.plv  = 2'd1;
        c.datf = 2'd2;
        c.datm = 2'd1;
        c.pg   = 1'b1;
        write_csr(`CSR_CRMD, c);
        read_check(`CSR_CRMD);
        c    = crmd_t'($random(seed));
        c.pg = 1'b1;
        c.da = 1'b1;
        write_csr(`CSR_CRMD, c);
        read_check(`CSR_CRMD);
        c    = crmd_t'($random(seed));
        c.pg = 1'b0;
        c.da = 1'b0;
        write_csr(`CSR_CRMD, c);
        read_check(`CSR_CRMD);

        // Exception entry from plv 3 with interrupts on
        c     = m_crmd;
        c.plv = 2'd3;
        c.ie  = 1'b1;
        write_csr(`CSR_CRMD, c);
        d = $random(seed);
        @(posedge clk);
        exception  <= 1'b1;
        expcode_in <= 7'h48;
        era_in     <= d;
        @(posedge clk);
        exception <= 1'b0;
        m_prmd.pplv = m_crmd.plv;
        m_prmd.pie  = m_crmd.ie;
        m_crmd.plv  = 2'd0;
        m_crmd.ie   = 1'b0;
        m_ecode     = 6'h08;
        m_esub      = 9'd1;
        m_era       = d;
        read_check(`CSR_PRMD);
        read_check(`CSR_CRMD);
        read_check(`CSR_ESTAT);
        compare_value("estat", expected_read(`CSR_ESTAT), estat);
        read_check(`CSR_ERA);
        compare_value("era_out", m_era, era_out);

        @(posedge clk);
        ertn <= 1'b1;
        @(posedge clk);
        ertn <= 1'b0;
        m_crmd.plv = m_prmd.pplv;
        m_crmd.ie  = m_prmd.pie;
        read_check(`CSR_CRMD);
        compare_value("crmd.plv", 2'd3, crmd.plv);

        // Direct updates from the pipeline, zero ecode drops esubcode
        d = $random(seed);
        @(posedge clk);
        wen_badv    <= 1'b1;
        badv_in     <= d;
        wen_era     <= 1'b1;
        era_in      <= ~d;
        wen_expcode <= 1'b1;
        expcode_in  <= 7'h40;
        @(posedge clk);
        wen_badv    <= 1'b0;
        wen_era     <= 1'b0;
        wen_expcode <= 1'b0;
        m_badv  = d;
        m_era   = ~d;
        m_ecode = 6'd0;
        m_esub  = 9'd0;
        read_check(`CSR_BADV);
        read_check(`CSR_ERA);
        read_check(`CSR_ESTAT);

        // Interrupt request and idle wakeup
        write_csr(`CSR_ECFG, 32'h0000_0004);
        drive_lines(8'h02);
        check_irq();
        drive_lines(8'h01);
        check_irq();
        drive_lines(8'h00);
        write_csr(`CSR_ESTAT, 32'h0000_0002);
        write_csr(`CSR_ECFG, 32'h0000_1fff);
        check_irq();
        read_check(`CSR_ECFG);
        read_check(`CSR_ESTAT);
        c    = m_crmd;
        c.ie = 1'b0;
        write_csr(`CSR_CRMD, c);
        check_irq();
        write_csr(`CSR_ESTAT, 32'd0);
        write_csr(`CSR_ECFG, 32'd0);
        check_irq();

        // One-shot timer
        t         = '0;
        t.en      = 1'b1;
        t.initval = 30'd5;
        write_csr(`CSR_TCFG, t);
        wait_timer_bit();
        read_check(`CSR_ESTAT);
        read_check(`CSR_TCFG);
        write_csr(`CSR_TICLR, 32'd1);
        read_check(`CSR_ESTAT);

        // Periodic timer fires again after a clear
        t.periodic = 1'b1;
        t.initval  = 30'd40;
        write_csr(`CSR_TCFG, t);
        wait_timer_bit();
        write_csr(`CSR_TICLR, 32'd1);
        read_check(`CSR_ESTAT);
        wait_timer_bit();
        read_check(`CSR_ESTAT);
        t.en = 1'b0;
        write_csr(`CSR_TCFG, t);
        write_csr(`CSR_TICLR, 32'd1);
        read_check(`CSR_ESTAT);

        if (i_dut.i_chk.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure("The bound checker reported an assertion failure");
        end
    end

endmodule

// ==== verif/csr_chk.sv ====
`timescale 1ns/1ns

module csr_chk (
    input logic           clk,
    input logic           aresetn,
    input csr_pkg::crmd_t crmd,
    input logic           cpu_interrupt,
    input logic           write_pending
);

    int unsigned fail_count = 0;

    // Mapped and direct translation are exclusive
    pg_da_exclusive: assert property (
        @(posedge clk) disable iff (!aresetn) !(crmd.pg && crmd.da))
    else begin
        $error("CRMD pg and da are both set");
        fail_count++;
    end

    irq_needs_ie: assert property (
        @(posedge clk) disable iff (!aresetn) cpu_interrupt |-> crmd.ie)
    else begin
        $error("cpu_interrupt high while CRMD ie is clear");
        fail_count++;
    end

    pending_low_after_reset: assert property (
        @(posedge clk) !aresetn |=> !write_pending)
    else begin
        $error("write_pending high in the cycle after reset");
        fail_count++;
    end

endmodule

bind csr_top csr_chk i_chk (
    .clk           (clk),
    .aresetn       (aresetn),
    .crmd          (crmd),
    .cpu_interrupt (cpu_interrupt),
    .write_pending (write_pending)
);

// ==== logic/csr_top.sv ====
`timescale 1ns/1ns

module csr_top (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen_in,
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::csr_data_t wdata_in,
    input  logic               d_idle,
    input  logic               flush,
    input  logic               exception,
    input  logic               ertn,
    input  logic               wen_expcode,
    input  logic [6:0]         expcode_in,
    input  logic               wen_era,
    input  csr_pkg::csr_data_t era_in,
    input  logic               wen_badv,
    input  csr_pkg::csr_data_t badv_in,
    input  logic [7:0]         hardware_interrupt,
    output csr_pkg::csr_data_t rdata,
    output csr_pkg::crmd_t     crmd,
    output csr_pkg::csr_data_t estat,
    output csr_pkg::csr_data_t era_out,
    output csr_pkg::csr_data_t eentry,
    output logic               cpu_interrupt,
    output logic               idle_over,
    output logic               write_pending
);
    import csr_pkg::*;

    logic      commit_en;
    csr_addr_t commit_addr;
    csr_data_t commit_data;
    prmd_t     prmd;
    csr_data_t ecfg;
    csr_data_t badv;
    logic      timer_pending;
    tcfg_t     tcfg;
    csr_data_t tval;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;

    csr_write_stage i_write_stage (
        .clk           (clk),
        .aresetn       (aresetn),
        .wen_in        (wen_in),
        .addr_in       (addr_in),
        .wdata_in      (wdata_in),
        .d_idle        (d_idle),
        .flush         (flush),
        .write_pending (write_pending),
        .commit_en     (commit_en),
        .commit_addr   (commit_addr),
        .commit_data   (commit_data)
    );

    csr_exc_regs i_exc_regs (
        .clk                (clk),
        .aresetn            (aresetn),
        .commit_en          (commit_en),
        .commit_addr        (commit_addr),
        .commit_data        (commit_data),
        .exception          (exception),
        .ertn               (ertn),
        .wen_expcode        (wen_expcode),
        .expcode_in         (expcode_in),
        .wen_era            (wen_era),
        .era_in             (era_in),
        .wen_badv           (wen_badv),
        .badv_in            (badv_in),
        .hardware_interrupt (hardware_interrupt),
        .timer_pending      (timer_pending),
        .crmd               (crmd),
        .prmd               (prmd),
        .ecfg               (ecfg),
        .estat              (estat),
        .era                (era_out),
        .badv               (badv),
        .eentry             (eentry),
        .cpu_interrupt      (cpu_interrupt),
        .idle_over          (idle_over)
    );

    csr_timer i_timer (
        .clk           (clk),
        .aresetn       (aresetn),
        .commit_en     (commit_en),
        .commit_addr   (commit_addr),
        .commit_data   (commit_data),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

    csr_scratch_regs i_scratch_regs (
        .clk         (clk),
        .aresetn     (aresetn),
        .commit_en   (commit_en),
        .commit_addr (commit_addr),
        .commit_data (commit_data),
        .save0       (save0),
        .save1       (save1),
        .save2       (save2),
        .save3       (save3)
    );

    csr_read_mux i_read_mux (
        .addr_in (addr_in),
        .crmd    (crmd),
        .prmd    (prmd),
        .ecfg    (ecfg),
        .estat   (estat),
        .era     (era_out),
        .badv    (badv),
        .eentry  (eentry),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3),
        .tcfg    (tcfg),
        .tval    (tval),
        .rdata   (rdata)
    );

endmodule

// ==== logic/csr_read_mux.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::crmd_t     crmd,
    input  csr_pkg::prmd_t     prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t badv,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::tcfg_t     tcfg,
    input  csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t rdata
);

    always_comb begin
        case (addr_in)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_BADV:   rdata = badv;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save0;
            `CSR_SAVE1:  rdata = save1;
            `CSR_SAVE2:  rdata = save2;
            `CSR_SAVE3:  rdata = save3;
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = tval;
            // Unmapped numbers and the write-only TICLR read zero
            default:     rdata = '0;
        endcase
    end

endmodule

// ==== logic/csr_scratch_regs.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_scratch_regs (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_data_t commit_data,
    output csr_pkg::csr_data_t save0,
    output csr_pkg::csr_data_t save1,
    output csr_pkg::csr_data_t save2,
    output csr_pkg::csr_data_t save3
);
    import csr_pkg::*;

    localparam csr_addr_t SAVE_ADDR [4] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};

    csr_data_t save_q [4];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (commit_en) begin
            for (int i = 0; i < 4; i++) begin
                if (commit_addr == SAVE_ADDR[i]) begin
                    save_q[i] <= commit_data;
                end
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_timer (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_data_t commit_data,
    output csr_pkg::tcfg_t     tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               timer_pending
);
    import csr_pkg::*;

    logic      load_q;
    logic      expire_q;
    csr_data_t reload_val;

    assign reload_val = {2'b00, tcfg.initval} + `CSR_TIMER_BIAS;

    // New configuration reloads the counter on the next edge
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg   <= '0;
            load_q <= 1'b0;
        end else begin
            load_q <= commit_en && commit_addr == `CSR_TCFG;
            if (commit_en && commit_addr == `CSR_TCFG) begin
                tcfg <= tcfg_t'(commit_data);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            expire_q <= 1'b0;
        end else if (load_q) begin
            tval     <= reload_val;
            expire_q <= 1'b0;
        end else if (tcfg.en) begin
            expire_q <= (tval == 32'd1);
            if (tval == 32'd0) begin
                // One-shot holds at zero
                if (tcfg.periodic) begin
                    tval <= reload_val;
                end
            end else begin
                tval <= tval - 32'd1;
            end
        end else begin
            expire_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_pending <= 1'b0;
        end else if (commit_en && commit_addr == `CSR_TICLR) begin
            timer_pending <= 1'b0;
        end else if (expire_q) begin
            timer_pending <= 1'b1;
        end
    end

endmodule

// ==== logic/csr_exc_regs.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_exc_regs (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit_en,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_data_t commit_data,
    input  logic               exception,
    input  logic               ertn,
    input  logic               wen_expcode,
    input  logic [6:0]         expcode_in,
    input  logic               wen_era,
    input  csr_pkg::csr_data_t era_in,
    input  logic               wen_badv,
    input  csr_pkg::csr_data_t badv_in,
    input  logic [7:0]         hardware_interrupt,
    input  logic               timer_pending,
    output csr_pkg::crmd_t     crmd,
    output csr_pkg::prmd_t     prmd,
    output csr_pkg::csr_data_t ecfg,
    output csr_pkg::csr_data_t estat,
    output csr_pkg::csr_data_t era,
    output csr_pkg::csr_data_t badv,
    output csr_pkg::csr_data_t eentry,
    output logic               cpu_interrupt,
    output logic               idle_over
);
    import csr_pkg::*;

    logic        exc_d_q;
    logic        exc_entry;
    logic [12:0] lie_q;
    logic [1:0]  is_soft_q;
    logic [5:0]  ecode_q;
    logic [8:0]  esubcode_q;
    int_vec_t    int_vec;
    crmd_t       wr_crmd;
    prmd_t       wr_prmd;

    // Rising edge of the exception input
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_d_q <= 1'b0;
        end else begin
            exc_d_q <= exception;
        end
    end

    assign exc_entry = exception && !exc_d_q;
    assign wr_crmd   = crmd_t'(commit_data);
    assign wr_prmd   = prmd_t'(commit_data);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd <= `CSR_CRMD_RESET;
        end else if (exc_entry) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (ertn) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (commit_en && commit_addr == `CSR_CRMD) begin
            crmd.plv  <= wr_crmd.plv;
            crmd.ie   <= wr_crmd.ie;
            crmd.datf <= wr_crmd.datf;
            crmd.datm <= wr_crmd.datm;
            // Only one of pg/da may be set
            if (wr_crmd.pg ^ wr_crmd.da) begin
                crmd.pg <= wr_crmd.pg;
                crmd.da <= wr_crmd.da;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd <= '0;
        end else if (exc_entry) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (commit_en && commit_addr == `CSR_PRMD) begin
            prmd.pplv <= wr_prmd.pplv;
            prmd.pie  <= wr_prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q <= '0;
        end else if (commit_en && commit_addr == `CSR_ECFG) begin
            lie_q <= commit_data[12:0] & `CSR_ECFG_LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            is_soft_q <= '0;
        end else if (commit_en && commit_addr == `CSR_ESTAT) begin
            is_soft_q <= commit_data[1:0];
        end
    end

    // esubcode only means something with a nonzero ecode
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (wen_expcode || exc_entry) begin
            ecode_q    <= expcode_in[5:0];
            esubcode_q <= (expcode_in[5:0] == 6'd0) ? 9'd0 : {8'd0, expcode_in[6]};
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
        end else begin
            if (wen_era || exc_entry) begin
                era <= era_in;
            end else if (commit_en && commit_addr == `CSR_ERA) begin
                era <= commit_data;
            end
            if (wen_badv) begin
                badv <= badv_in;
            end else if (commit_en && commit_addr == `CSR_BADV) begin
                badv <= commit_data;
            end
            if (commit_en && commit_addr == `CSR_EENTRY) begin
                eentry <= commit_data & `CSR_EENTRY_MASK;
            end
        end
    end

    // Hardware lines and timer are live, ipi and bit 10 stay low
    assign int_vec = {1'b0, timer_pending, 1'b0, hardware_interrupt, is_soft_q};

    assign ecfg  = {19'd0, lie_q};
    assign estat = {1'b0, esubcode_q, ecode_q, 3'd0, int_vec};

    assign cpu_interrupt = crmd.ie && |(lie_q & int_vec);
    // Any pending line ends idle, enabled or not
    assign idle_over     = |int_vec;

endmodule

// ==== logic/csr_write_stage.sv ====
`timescale 1ns/1ns
`include "csr_config.svh"

module csr_write_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen_in,
    input  csr_pkg::csr_addr_t addr_in,
    input  csr_pkg::csr_data_t wdata_in,
    input  logic               d_idle,
    input  logic               flush,
    output logic               write_pending,
    output logic               commit_en,
    output csr_pkg::csr_addr_t commit_addr,
    output csr_pkg::csr_data_t commit_data
);
    import csr_pkg::*;

    localparam int CNT_W = $clog2(`CSR_COMMIT_IDLE + 1);
    localparam logic [CNT_W-1:0] LAST_IDLE = CNT_W'(`CSR_COMMIT_IDLE - 1);

    logic             pending_q;
    logic [CNT_W-1:0] idle_cnt_q;
    csr_addr_t        addr_q;
    csr_data_t        data_q;

    // Fires on the last idle cycle, unless flushed or replaced by a new write
    assign commit_en = pending_q && d_idle && (idle_cnt_q == LAST_IDLE) && !flush && !wen_in;

    assign write_pending = pending_q;
    assign commit_addr   = addr_q;
    assign commit_data   = data_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pending_q  <= 1'b0;
            idle_cnt_q <= '0;
        end else if (flush) begin
            pending_q  <= 1'b0;
            idle_cnt_q <= '0;
        end else if (wen_in) begin
            pending_q  <= 1'b1;
            idle_cnt_q <= '0;
        end else if (commit_en) begin
            pending_q  <= 1'b0;
            idle_cnt_q <= '0;
        end else if (pending_q && d_idle) begin
            idle_cnt_q <= idle_cnt_q + CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wen_in && !flush) begin
            addr_q <= addr_in;
            data_q <= wdata_in;
        end
    end

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // One CSR value and one CSR number
    typedef logic [31:0] csr_data_t;
    typedef logic [13:0] csr_addr_t;

    // Current mode
    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    // Mode saved on exception entry
    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    // Interrupt vector, same layout as ECFG lie and ESTAT is
    //   [1:0]  software
    //   [9:2]  hardware lines
    //   [10]   reserved
    //   [11]   timer
    //   [12]   inter-processor, tied low
    typedef logic [12:0] int_vec_t;

    // Timer configuration
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

endpackage

// ==== logic/csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// CSR numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// Reset values
`define CSR_CRMD_RESET  32'h0000_0008

// Writable masks
// ECFG bit 10 has no interrupt line behind it
`define CSR_ECFG_LIE_MASK  13'h1bff
// Entry address is 64-byte aligned
`define CSR_EENTRY_MASK    32'hffff_ffc0

// Idle cycles a staged write waits before it commits
`define CSR_COMMIT_IDLE  3

// Added to initval at load, so an initval of 0 still fires
`define CSR_TIMER_BIAS  32'd1

`endif
